//--- common/mm_ram_pkg.sv
// Shared types and constants for the simulation memory block on the core's
// data port. Holds the OBI request/response structs, the decoder's selector
// struct and the pseudo-peripheral address map. Compile this file first.

`default_nettype none

package mm_ram_pkg;

  // meaningful widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    logic  err;
  } obi_resp_t;

  // where a granted request goes
  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_PERIPH,
    TGT_ERR
  } target_e;

  // peripheral register selector
  typedef enum logic [2:0] {
    REG_NONE,
    REG_PRINT,
    REG_STATUS,
    REG_EXIT,
    REG_TIMER_MASK,
    REG_TIMER_VAL,
    REG_TIMER_CNT
  } reg_e;

  // accepted request as seen by the peripherals and response stage
  typedef struct packed {
    logic    valid;
    target_e target;
    reg_e    regsel;
    logic    we;
    data_t   wdata;
  } mm_sel_t;

  // pseudo-peripheral address map
  localparam addr_t ADDR_PRINT      = 32'h1000_0000;
  localparam addr_t ADDR_STATUS     = 32'h2000_0000;
  localparam addr_t ADDR_EXIT       = 32'h2000_0004;
  localparam addr_t ADDR_TIMER_MASK = 32'h1500_0000;
  localparam addr_t ADDR_TIMER_VAL  = 32'h1500_0004;
  localparam addr_t ADDR_TIMER_CNT  = 32'h1500_1000;

  localparam data_t PASS_MAGIC   = 32'd123456789;
  localparam data_t FAIL_CODE    = 32'd1;
  localparam int    TIMER_IRQ_ID = 7;

endpackage

`default_nettype wire

//--- mm_ram.f
+incdir+tb
common/mm_ram_pkg.sv
verilog/mm_addr_decode.sv
verilog/sram_bank.sv
periph/sim_timer.sv
periph/test_ctrl.sv
verilog/mm_resp_stage.sv
verilog/mm_ram.sv
tb/tb_mm_ram.sv

//--- periph/sim_timer.sv
// Countdown timer pseudo-peripheral. Software writes the interrupt mask and
// a start count; the count runs down once per cycle and raises the timer
// interrupt on the step from 1 to 0. An acknowledge with the timer's id
// clears it.

`default_nettype none

module sim_timer (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  mm_ram_pkg::mm_sel_t  sel_i,
  input  wire logic [4:0]      irq_id_i,
  input  wire logic            irq_ack_i,
  output logic                 irq_timer_o,
  output mm_ram_pkg::data_t    count_o
);

  mm_ram_pkg::data_t mask_q;
  mm_ram_pkg::data_t cnt_q;
  logic              irq_q;
  logic              reg_wr;
  logic              mask_wr;
  logic              val_wr;
  logic              irq_clr;

  assign reg_wr  = sel_i.valid && sel_i.we && sel_i.target == mm_ram_pkg::TGT_PERIPH;
  assign mask_wr = reg_wr && sel_i.regsel == mm_ram_pkg::REG_TIMER_MASK;
  assign val_wr  = reg_wr && sel_i.regsel == mm_ram_pkg::REG_TIMER_VAL;
  assign irq_clr = irq_ack_i && irq_id_i == 5'(mm_ram_pkg::TIMER_IRQ_ID);

  // a register write wins over counting
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
      cnt_q  <= '0;
      irq_q  <= 1'b0;
    end else begin
      if (mask_wr) begin
        mask_q <= sel_i.wdata;
      end else if (val_wr) begin
        cnt_q <= sel_i.wdata;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end

      if (irq_clr) begin
        irq_q <= 1'b0;
      end else if (!mask_wr && !val_wr && cnt_q == 32'd1) begin
        irq_q <= irq_q | mask_q[mm_ram_pkg::TIMER_IRQ_ID];
      end
    end
  end

  assign irq_timer_o = irq_q;
  assign count_o     = cnt_q;

  masked_irq_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(irq_timer_o) |-> mask_q[mm_ram_pkg::TIMER_IRQ_ID]
  ) else $error("timer irq raised with mask bit clear");

endmodule

`default_nettype wire

//--- periph/test_ctrl.sv
// Test-control pseudo-peripheral. Turns accepted writes to the print,
// status and exit registers into one-cycle strobes the cycle after the
// write, for the testbench to log and to end the run.

`default_nettype none

module test_ctrl (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  mm_ram_pkg::mm_sel_t  sel_i,
  output logic                 print_valid_o,
  output logic [7:0]           print_char_o,
  output logic                 tests_passed_o,
  output logic                 tests_failed_o,
  output logic                 exit_valid_o,
  output mm_ram_pkg::data_t    exit_value_o
);

  logic              reg_wr;
  logic              print_wr;
  logic              status_wr;
  logic              exit_wr;
  logic              print_valid_q;
  logic              passed_q;
  logic              failed_q;
  logic              exit_valid_q;
  logic [7:0]        print_char_q;
  mm_ram_pkg::data_t exit_value_q;

  assign reg_wr    = sel_i.valid && sel_i.we && sel_i.target == mm_ram_pkg::TGT_PERIPH;
  assign print_wr  = reg_wr && sel_i.regsel == mm_ram_pkg::REG_PRINT;
  assign status_wr = reg_wr && sel_i.regsel == mm_ram_pkg::REG_STATUS;
  assign exit_wr   = reg_wr && sel_i.regsel == mm_ram_pkg::REG_EXIT;

  // strobes, high for exactly one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      print_valid_q <= 1'b0;
      passed_q      <= 1'b0;
      failed_q      <= 1'b0;
      exit_valid_q  <= 1'b0;
    end else begin
      print_valid_q <= print_wr;
      passed_q      <= status_wr && sel_i.wdata == mm_ram_pkg::PASS_MAGIC;
      failed_q      <= status_wr && sel_i.wdata == mm_ram_pkg::FAIL_CODE;
      exit_valid_q  <= exit_wr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (print_wr) print_char_q <= sel_i.wdata[7:0];
    if (exit_wr) exit_value_q <= sel_i.wdata;
  end

  assign print_valid_o  = print_valid_q;
  assign print_char_o   = print_char_q;
  assign tests_passed_o = passed_q;
  assign tests_failed_o = failed_q;
  assign exit_valid_o   = exit_valid_q;
  assign exit_value_o   = exit_value_q;

endmodule

`default_nettype wire

//--- tb/mm_ram_tasks.svh
// Bus tasks, random source and value check for the mm_ram testbench.
// Included inside the testbench module, so it uses its signals directly.

`ifndef MM_RAM_TASKS_SVH
`define MM_RAM_TASKS_SVH

  function automatic mm_ram_pkg::data_t xorshift32(input mm_ram_pkg::data_t x);
    mm_ram_pkg::data_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input mm_ram_pkg::data_t exp,
                             input mm_ram_pkg::data_t act);
    checks++;
    if (exp !== act) begin
      $display("[FAIL] t=%0t %s expected %08x got %08x", $time, name, exp, act);
      errors++;
    end
  endtask

  // one OBI transfer: hold req until gnt, then wait for rvalid
  task automatic bus_access(input logic we, input mm_ram_pkg::addr_t addr,
                            input mm_ram_pkg::data_t wdata, input mm_ram_pkg::be_t be,
                            output mm_ram_pkg::data_t rdata, output logic err);
    int n;
    @(posedge clk_i);
    #1;
    req.req   = 1'b1;
    req.we    = we;
    req.be    = be;
    req.addr  = addr;
    req.wdata = wdata;
    n = 0;
    @(negedge clk_i);
    while (!resp.gnt && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    rdata = '0;
    err   = 1'b0;
    if (!resp.gnt) begin
      $display("no grant within %0d cycles for access to %08x", TIMEOUT, addr);
      errors++;
    end else begin
      gnt_cycle = cycle + 1;
      @(posedge clk_i);
      #1;
      req = '0;
      n = 0;
      @(negedge clk_i);
      while (!resp.rvalid && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
      end
      if (!resp.rvalid) begin
        $display("no rvalid within %0d cycles for access to %08x", TIMEOUT, addr);
        errors++;
      end
      rdata = resp.rdata;
      err   = resp.err;
    end
  endtask

  task automatic obi_write(input mm_ram_pkg::addr_t addr, input mm_ram_pkg::data_t wdata,
                           input mm_ram_pkg::be_t be);
    mm_ram_pkg::data_t rd;
    logic err;
    bus_access(1'b1, addr, wdata, be, rd, err);
    check_value("resp.err", 0, err);
  endtask

  task automatic obi_read(input mm_ram_pkg::addr_t addr, output mm_ram_pkg::data_t rdata,
                          output logic err);
    bus_access(1'b0, addr, '0, 4'hf, rdata, err);
  endtask

`endif

//--- tb/tb_mm_ram.sv
// Directed testbench for mm_ram. Runs the RAM, test-control, timer and
// unmapped-read tests on the data port and prints a summary at the end.

`default_nettype none

module tb_mm_ram;

  localparam int unsigned NUM_BYTES = 65536;
  localparam int TIMEOUT = 50;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  mm_ram_pkg::obi_req_t  req;
  mm_ram_pkg::obi_resp_t resp;
  logic [4:0]            irq_id;
  logic                  irq_ack;
  logic                  irq_timer;
  logic                  print_valid;
  logic                  passed;
  logic                  failed;
  logic                  exit_valid;
  logic [7:0]            print_char;
  mm_ram_pkg::data_t     exit_value;
  mm_ram_pkg::data_t     rng = 32'hec84;
  int unsigned           cycle = 0;
  int unsigned           gnt_cycle = 0;
  int                    errors = 0;
  int                    checks = 0;
  int                    tests_run = 0;

  `include "mm_ram_tasks.svh"

  mm_ram #(.NUM_BYTES(NUM_BYTES)) uut (
    .clk_i(clk_i), .rst_ni(rst_ni), .data_req_i(req), .data_resp_o(resp),
    .irq_id_i(irq_id), .irq_ack_i(irq_ack), .irq_timer_o(irq_timer),
    .print_valid_o(print_valid), .print_char_o(print_char),
    .tests_passed_o(passed), .tests_failed_o(failed),
    .exit_valid_o(exit_valid), .exit_value_o(exit_value)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  task automatic finish_test(input string name, input int err_at_start);
    tests_run++;
    $display("test %s: %0d errors", name, errors - err_at_start);
  endtask

  task automatic test_ram_round_trip();
    int err0;
    mm_ram_pkg::addr_t addr;
    mm_ram_pkg::data_t rd;
    logic err;
    mm_ram_pkg::data_t model [mm_ram_pkg::addr_t];
    mm_ram_pkg::addr_t addrs [$];
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      rng = xorshift32(rng);
      addr = rng & mm_ram_pkg::addr_t'(NUM_BYTES - 1) & 32'hffff_fffc;
      rng = xorshift32(rng);
      obi_write(addr, rng, 4'hf);
      // repeated addresses keep the last word written
      model[addr] = rng;
      addrs.push_back(addr);
    end
    foreach (addrs[i]) begin
      obi_read(addrs[i], rd, err);
      check_value("resp.err", 0, err);
      check_value("resp.rdata", model[addrs[i]], rd);
    end
    finish_test("ram round trip", err0);
  endtask

  task automatic test_byte_enables();
    int err0;
    mm_ram_pkg::data_t rd;
    mm_ram_pkg::data_t exp;
    logic err;
    err0 = errors;
    rng = xorshift32(rng);
    obi_write(32'h40, 32'h1122_3344, 4'hf);
    obi_write(32'h40, rng, 4'b0100);
    exp = {8'h11, rng[23:16], 8'h33, 8'h44};
    obi_read(32'h40, rd, err);
    check_value("resp.err", 0, err);
    check_value("resp.rdata", exp, rd);
    finish_test("byte enables", err0);
  endtask

  task automatic test_test_ctrl();
    int err0;
    err0 = errors;
    obi_write(mm_ram_pkg::ADDR_PRINT, 32'h41, 4'hf);
    check_value("print_valid_o", 1, print_valid);
    check_value("print_char_o", 8'h41, print_char);
    obi_write(mm_ram_pkg::ADDR_STATUS, mm_ram_pkg::PASS_MAGIC, 4'hf);
    check_value("tests_passed_o", 1, passed);
    check_value("tests_failed_o", 0, failed);
    obi_write(mm_ram_pkg::ADDR_STATUS, mm_ram_pkg::FAIL_CODE, 4'hf);
    check_value("tests_passed_o", 0, passed);
    check_value("tests_failed_o", 1, failed);
    obi_write(mm_ram_pkg::ADDR_STATUS, 32'd5, 4'hf);
    check_value("tests_passed_o", 0, passed);
    check_value("tests_failed_o", 0, failed);
    rng = xorshift32(rng);
    obi_write(mm_ram_pkg::ADDR_EXIT, rng, 4'hf);
    check_value("exit_valid_o", 1, exit_valid);
    check_value("exit_value_o", rng, exit_value);
    // strobe lasts a single cycle
    @(negedge clk_i);
    check_value("exit_valid_o", 0, exit_valid);
    finish_test("test control", err0);
  endtask

  task automatic send_ack(input logic [4:0] id);
    @(posedge clk_i);
    #1;
    irq_ack = 1'b1;
    irq_id  = id;
    @(posedge clk_i);
    #1;
    irq_ack = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic test_timer_irq();
    int err0;
    err0 = errors;
    obi_write(mm_ram_pkg::ADDR_TIMER_MASK, 32'h80, 4'hf);
    obi_write(mm_ram_pkg::ADDR_TIMER_VAL, 32'd10, 4'hf);
    // count loads at the grant edge, irq follows ten edges later
    while (cycle - gnt_cycle < 10) begin
      check_value("irq_timer_o", 0, irq_timer);
      @(negedge clk_i);
    end
    check_value("irq_timer_o", 1, irq_timer);
    send_ack(5'd3);
    check_value("irq_timer_o", 1, irq_timer);
    send_ack(5'd7);
    check_value("irq_timer_o", 0, irq_timer);
    finish_test("timer interrupt", err0);
  endtask

  task automatic test_masked_timer();
    int err0;
    mm_ram_pkg::data_t rd;
    logic err;
    err0 = errors;
    obi_write(mm_ram_pkg::ADDR_TIMER_MASK, 32'h0, 4'hf);
    obi_write(mm_ram_pkg::ADDR_TIMER_VAL, 32'd5, 4'hf);
    repeat (20) begin
      @(negedge clk_i);
      check_value("irq_timer_o", 0, irq_timer);
    end
    obi_read(mm_ram_pkg::ADDR_TIMER_CNT, rd, err);
    check_value("resp.err", 0, err);
    check_value("resp.rdata", 0, rd);
    finish_test("masked timer", err0);
  endtask

  task automatic test_unmapped_read();
    int err0;
    mm_ram_pkg::data_t rd;
    logic err;
    err0 = errors;
    obi_read(mm_ram_pkg::addr_t'(NUM_BYTES + 32'h100), rd, err);
    check_value("resp.err", 1, err);
    check_value("resp.rdata", 0, rd);
    finish_test("unmapped read", err0);
  endtask

  initial begin
    rst_ni  = 1'b0;
    req     = '0;
    irq_id  = '0;
    irq_ack = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_ram_round_trip();
    test_byte_enables();
    test_test_ctrl();
    test_timer_irq();
    test_masked_timer();
    test_unmapped_read();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/mm_addr_decode.sv
// Address decoder for the data port. Classifies each request as RAM,
// peripheral register or unmapped, grants it in the same cycle and drives
// the RAM strobes plus the selector shared by the peripherals.

`default_nettype none

module mm_addr_decode #(
  parameter int unsigned NUM_BYTES = 65536
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  mm_ram_pkg::obi_req_t       req_i,
  output logic                       gnt_o,
  output mm_ram_pkg::mm_sel_t        sel_o,
  output logic                       ram_req_o,
  output logic                       ram_we_o,
  output mm_ram_pkg::be_t            ram_be_o,
  output mm_ram_pkg::addr_t          ram_addr_o,
  output mm_ram_pkg::data_t          ram_wdata_o
);

  mm_ram_pkg::reg_e    reg_sel;
  mm_ram_pkg::target_e target;
  logic                periph_hit;

  // register match on the exact address
  always_comb begin
    case (req_i.addr)
      mm_ram_pkg::ADDR_PRINT:      reg_sel = mm_ram_pkg::REG_PRINT;
      mm_ram_pkg::ADDR_STATUS:     reg_sel = mm_ram_pkg::REG_STATUS;
      mm_ram_pkg::ADDR_EXIT:       reg_sel = mm_ram_pkg::REG_EXIT;
      mm_ram_pkg::ADDR_TIMER_MASK: reg_sel = mm_ram_pkg::REG_TIMER_MASK;
      mm_ram_pkg::ADDR_TIMER_VAL:  reg_sel = mm_ram_pkg::REG_TIMER_VAL;
      mm_ram_pkg::ADDR_TIMER_CNT:  reg_sel = mm_ram_pkg::REG_TIMER_CNT;
      default:                     reg_sel = mm_ram_pkg::REG_NONE;
    endcase
  end

  // only the count is readable, everything else is write only
  assign periph_hit = req_i.we ?
      (reg_sel != mm_ram_pkg::REG_NONE && reg_sel != mm_ram_pkg::REG_TIMER_CNT) :
      (reg_sel == mm_ram_pkg::REG_TIMER_CNT);

  assign target = periph_hit ? mm_ram_pkg::TGT_PERIPH :
                  (req_i.addr < mm_ram_pkg::addr_t'(NUM_BYTES)) ? mm_ram_pkg::TGT_RAM :
                  mm_ram_pkg::TGT_ERR;

  // unmapped reads get an error response, unmapped writes stall
  assign gnt_o = req_i.req && (target != mm_ram_pkg::TGT_ERR || !req_i.we);

  assign sel_o.valid  = gnt_o;
  assign sel_o.target = target;
  assign sel_o.regsel = periph_hit ? reg_sel : mm_ram_pkg::REG_NONE;
  assign sel_o.we     = req_i.we;
  assign sel_o.wdata  = req_i.wdata;

  assign ram_req_o   = gnt_o && target == mm_ram_pkg::TGT_RAM;
  assign ram_we_o    = req_i.we;
  assign ram_be_o    = req_i.be;
  assign ram_addr_o  = req_i.addr;
  assign ram_wdata_o = req_i.wdata;

  // the master must never write outside the map
  unmapped_write_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i.req && req_i.we |-> target != mm_ram_pkg::TGT_ERR
  ) else $error("unmapped write to %08x", req_i.addr);

endmodule

`default_nettype wire

//--- verilog/mm_ram.sv
// Top level of the simulation memory block for the core's data port.
// Set NUM_BYTES for the RAM size; drive one OBI master into data_req_i.
// Wires the decoder, the RAM, the timer and test-control peripherals and
// the response stage together.

`default_nettype none

module mm_ram #(
  parameter int unsigned NUM_BYTES = 65536
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  mm_ram_pkg::obi_req_t   data_req_i,
  output mm_ram_pkg::obi_resp_t  data_resp_o,
  input  wire logic [4:0]        irq_id_i,
  input  wire logic              irq_ack_i,
  output logic                   irq_timer_o,
  output logic                   print_valid_o,
  output logic [7:0]             print_char_o,
  output logic                   tests_passed_o,
  output logic                   tests_failed_o,
  output logic                   exit_valid_o,
  output mm_ram_pkg::data_t      exit_value_o
);

  logic                gnt;
  mm_ram_pkg::mm_sel_t sel;
  logic                ram_req;
  logic                ram_we;
  mm_ram_pkg::be_t     ram_be;
  mm_ram_pkg::addr_t   ram_addr;
  mm_ram_pkg::data_t   ram_wdata;
  mm_ram_pkg::data_t   ram_rdata;
  mm_ram_pkg::data_t   timer_count;

  mm_addr_decode #(
    .NUM_BYTES(NUM_BYTES)
  ) u_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (data_req_i),
    .gnt_o      (gnt),
    .sel_o      (sel),
    .ram_req_o  (ram_req),
    .ram_we_o   (ram_we),
    .ram_be_o   (ram_be),
    .ram_addr_o (ram_addr),
    .ram_wdata_o(ram_wdata)
  );

  sram_bank #(
    .NUM_BYTES(NUM_BYTES)
  ) u_sram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (ram_req),
    .we_i   (ram_we),
    .be_i   (ram_be),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .rdata_o(ram_rdata)
  );

  sim_timer u_timer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .sel_i      (sel),
    .irq_id_i   (irq_id_i),
    .irq_ack_i  (irq_ack_i),
    .irq_timer_o(irq_timer_o),
    .count_o    (timer_count)
  );

  test_ctrl u_test_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sel_i         (sel),
    .print_valid_o (print_valid_o),
    .print_char_o  (print_char_o),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  mm_resp_stage u_resp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .gnt_i        (gnt),
    .sel_i        (sel),
    .ram_rdata_i  (ram_rdata),
    .timer_count_i(timer_count),
    .resp_o       (data_resp_o)
  );

endmodule

`default_nettype wire

//--- verilog/mm_resp_stage.sv
// Response side of the data port. Passes the grant straight through and,
// one cycle later, returns rvalid with the read data of the target that
// took the request, or an error for an unmapped read.

`default_nettype none

module mm_resp_stage (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              gnt_i,
  input  mm_ram_pkg::mm_sel_t    sel_i,
  input  mm_ram_pkg::data_t      ram_rdata_i,
  input  mm_ram_pkg::data_t      timer_count_i,
  output mm_ram_pkg::obi_resp_t  resp_o
);

  logic                rvalid_q;
  mm_ram_pkg::target_e tgt_q;
  mm_ram_pkg::reg_e    reg_q;
  mm_ram_pkg::data_t   count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      tgt_q    <= mm_ram_pkg::TGT_RAM;
      reg_q    <= mm_ram_pkg::REG_NONE;
    end else begin
      rvalid_q <= gnt_i;
      if (gnt_i) begin
        tgt_q <= sel_i.target;
        reg_q <= sel_i.regsel;
      end
    end
  end

  // count as it was when the read was granted
  always_ff @(posedge clk_i) begin
    if (gnt_i) count_q <= timer_count_i;
  end

  always_comb begin
    resp_o.gnt    = gnt_i;
    resp_o.rvalid = rvalid_q;
    resp_o.err    = rvalid_q && tgt_q == mm_ram_pkg::TGT_ERR;
    case (tgt_q)
      mm_ram_pkg::TGT_RAM:    resp_o.rdata = ram_rdata_i;
      mm_ram_pkg::TGT_PERIPH: resp_o.rdata = (reg_q == mm_ram_pkg::REG_TIMER_CNT) ? count_q : '0;
      default:                resp_o.rdata = '0;
    endcase
  end

  // the selector must mark the request that rvalid answers
  rvalid_after_gnt_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_o.rvalid |-> $past(sel_i.valid)
  ) else $error("rvalid without a granted request");

endmodule

`default_nettype wire

//--- verilog/sram_bank.sv
// Single-port word RAM for the data port. Writes merge the enabled bytes,
// reads return the addressed word on the cycle after the request.

`default_nettype none

module sram_bank #(
  parameter int unsigned NUM_BYTES = 65536
) (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          req_i,
  input  wire logic          we_i,
  input  mm_ram_pkg::be_t    be_i,
  input  mm_ram_pkg::addr_t  addr_i,
  input  mm_ram_pkg::data_t  wdata_i,
  output mm_ram_pkg::data_t  rdata_o
);

  localparam int unsigned NumWords  = NUM_BYTES / 4;
  localparam int unsigned AddrWidth = $clog2(NUM_BYTES);

  mm_ram_pkg::data_t       mem [NumWords];
  mm_ram_pkg::data_t       rdata_q;
  logic [AddrWidth-3:0]    word_idx;

  assign word_idx = addr_i[AddrWidth-1:2];

  // byte lane write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire
